// ==== all.f ====
logic/regFilePkg.sv
logic/gprBankedArray.sv
logic/specialReg.sv
logic/operandSelect.sv
logic/forwardNetwork.sv
logic/gprRegFile.sv
verif/gprRegFileTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the register file testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f all.f --top-module gprRegFileTb -o gprRegFileSim
if [ $? -ne 0 ]; then
	echo "Compile step failed"
	exit 1
fi

output=$(./obj_dir/gprRegFileSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "^Verification passed$"; then
	exit 0
fi
echo "Pass line not found in simulation output"
exit 1

// ==== verif/gprRegFileTb.sv ====
//////////////////////////////
// Testbench for the operand register file
// Clock, reset, random stimulus,
// register model and assertions
//////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module gprRegFileTb;

	localparam int edgeTimeout = 100;	// ns of polling per wait

	logic clock;
	logic reset;
	logic hold;
	logic ex3Flush;
	regFilePkg::regIdT ex1IdA, ex1IdB, ex2IdA, ex2IdB, ex3IdA, ex3IdB;
	regFilePkg::dataT ex1ValueA, ex1ValueB, ex2ValueA, ex2ValueB, ex3ValueA, ex3ValueB;
	regFilePkg::regIdT rsId, rtId, ruId, rvId;
	regFilePkg::pcT pcValue;
	regFilePkg::immT immA, immB;
	regFilePkg::dataT dlrIn, dhrIn, spIn;
	regFilePkg::dataT rsValue, rtValue, ruValue, rvValue;
	regFilePkg::dataT dlrOut, dhrOut, spOut;

	// Reference state
	regFilePkg::dataT gprModel [32];
	regFilePkg::dataT dlrModel, dhrModel, spModel;

	logic [63:0] rngState = 64'd62;
	int riseCount = 0;
	int fallCount = 0;

	gprRegFile #(.registerCount(regFilePkg::gprCount)) dut (.*);

	always #20 clock = ~clock;

	always @(posedge clock) riseCount <= riseCount + 1;
	always @(negedge clock) fallCount <= fallCount + 1;

	function automatic logic [63:0] nextRandom();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 7);
		rngState = rngState ^ (rngState << 17);
		return rngState;
	endfunction

	function automatic regFilePkg::regIdT randomGpr();
		logic [63:0] r;
		r = nextRandom();
		return {1'b0, r[4:0]};
	endfunction

	// Mostly general registers, sometimes a special one
	function automatic regFilePkg::regIdT randomDest();
		logic [63:0] r;
		r = nextRandom();
		case (r[2:0])
			3'd0: return regFilePkg::idDlr;
			3'd1: return regFilePkg::idDhr;
			3'd2: return regFilePkg::idSp;
			default: return {1'b0, r[7:3]};
		endcase
	endfunction

	// Expected operand from the model, then the newest in-flight result
	function automatic regFilePkg::dataT expectOperand(input regFilePkg::regIdT id,
			input bit pcAllowed, input regFilePkg::immT imm);
		regFilePkg::dataT result;
		result = '0;
		if (!id[5]) result = gprModel[id[4:0]];
		else if (id == regFilePkg::idDlr) result = dlrModel;
		else if (id == regFilePkg::idDhr) result = dhrModel;
		else if (id == regFilePkg::idSp) result = spModel;
		else if (id == regFilePkg::idPc && pcAllowed)
			result = regFilePkg::dataT'(pcValue & ~48'd1);
		else if (id == regFilePkg::idImm) result = regFilePkg::dataT'($signed(imm));
		if (id != regFilePkg::idImm && id != regFilePkg::idZero) begin
			if (id == ex1IdA) result = ex1ValueA;
			else if (id == ex1IdB) result = ex1ValueB;
			else if (id == ex2IdA) result = ex2ValueA;
			else if (id == ex2IdB) result = ex2ValueB;
			else if (id == ex3IdA) result = ex3ValueA;
			else if (id == ex3IdB) result = ex3ValueB;
		end
		return result;
	endfunction

	function automatic regFilePkg::dataT specialNext(input regFilePkg::regIdT id,
			input regFilePkg::dataT loadValue);
		if (ex3IdB == id) return ex3ValueB;	// Lane B first
		if (ex3IdA == id) return ex3ValueA;
		return loadValue;
	endfunction

	task automatic reportFailure(input string message);
		$display("CHECK FAILED at %0t: %s", $time, message);
		$display("Verification failed");
		$fatal(1, "Stopping at first error");
	endtask

	task automatic waitEdge(input bit rising);
		int startCount;
		int waited;
		startCount = rising ? riseCount : fallCount;
		waited = 0;
		while ((rising ? riseCount : fallCount) == startCount) begin
			#1;
			waited++;
			if (waited > edgeTimeout) begin
				$display("Timed out at %0t waiting for a clock edge", $time);
				$display("Verification failed");
				$fatal(1, "Clock stopped");
			end
		end
	endtask

	task automatic checkOutputs();
		regFilePkg::dataT expected;
		expected = expectOperand(rsId, 1'b1, immA);
		assert (rsValue === expected) else
			reportFailure($sformatf("Rs id %0d read %h, expected %h", rsId, rsValue, expected));
		expected = expectOperand(rtId, 1'b0, immA);
		assert (rtValue === expected) else
			reportFailure($sformatf("Rt id %0d read %h, expected %h", rtId, rtValue, expected));
		expected = expectOperand(ruId, 1'b0, immB);
		assert (ruValue === expected) else
			reportFailure($sformatf("Ru id %0d read %h, expected %h", ruId, ruValue, expected));
		expected = expectOperand(rvId, 1'b0, immB);
		assert (rvValue === expected) else
			reportFailure($sformatf("Rv id %0d read %h, expected %h", rvId, rvValue, expected));
		assert (dlrOut === dlrModel) else
			reportFailure($sformatf("DLR is %h, expected %h", dlrOut, dlrModel));
		assert (dhrOut === dhrModel) else
			reportFailure($sformatf("DHR is %h, expected %h", dhrOut, dhrModel));
		assert (spOut === spModel) else
			reportFailure($sformatf("SP is %h, expected %h", spOut, spModel));
	endtask

	// Applies the EX3 writes that the edge just committed
	task automatic updateModel();
		if (!hold && !ex3Flush) begin
			dlrModel = specialNext(regFilePkg::idDlr, dlrIn);
			dhrModel = specialNext(regFilePkg::idDhr, dhrIn);
			spModel = specialNext(regFilePkg::idSp, spIn);
			if (!ex3IdA[5]) gprModel[ex3IdA[4:0]] = ex3ValueA;
			if (!ex3IdB[5]) gprModel[ex3IdB[4:0]] = ex3ValueB;	// Lane B lands last
		end
	endtask

	// Check mid cycle, then step past the rising edge
	task automatic runCycle();
		waitEdge(1'b0);
		checkOutputs();
		waitEdge(1'b1);
		updateModel();
		#1;
	endtask

	task automatic driveIdle();
		hold = 1'b0;
		ex3Flush = 1'b0;
		ex1IdA = regFilePkg::idZero;
		ex1IdB = regFilePkg::idZero;
		ex2IdA = regFilePkg::idZero;
		ex2IdB = regFilePkg::idZero;
		ex3IdA = regFilePkg::idZero;
		ex3IdB = regFilePkg::idZero;
		ex1ValueA = '0;
		ex1ValueB = '0;
		ex2ValueA = '0;
		ex2ValueB = '0;
		ex3ValueA = '0;
		ex3ValueB = '0;
		rsId = regFilePkg::idZero;
		rtId = regFilePkg::idZero;
		ruId = regFilePkg::idZero;
		rvId = regFilePkg::idZero;
	endtask

	// Every GPR gets a known value before any read
	task automatic writeAllRegisters();
		int i;
		for (i = 0; i < 16; i++) begin
			driveIdle();
			ex3IdA = regFilePkg::regIdT'(2 * i);
			ex3IdB = regFilePkg::regIdT'(2 * i + 1);
			ex3ValueA = nextRandom();
			ex3ValueB = nextRandom();
			runCycle();
		end
	endtask

	task automatic randomWrites();
		int i;
		for (i = 0; i < 64; i++) begin
			driveIdle();
			ex3IdA = randomGpr();
			ex3IdB = (i % 4 == 0) ? ex3IdA : randomGpr();	// Same target on both lanes
			ex3ValueA = nextRandom();
			ex3ValueB = nextRandom();
			rsId = randomGpr();
			rtId = randomGpr();
			ruId = randomGpr();
			rvId = randomGpr();
			runCycle();
		end
	endtask

	// Writes under hold or flush, then read the targets back
	task automatic blockedWrites();
		int i;
		logic [63:0] r;
		regFilePkg::regIdT targetA;
		regFilePkg::regIdT targetB;
		for (i = 0; i < 16; i++) begin
			driveIdle();
			r = nextRandom();
			hold = r[0];
			ex3Flush = !r[0] | r[1];
			targetA = randomDest();
			targetB = randomDest();
			ex3IdA = targetA;
			ex3IdB = targetB;
			ex3ValueA = nextRandom();
			ex3ValueB = nextRandom();
			dlrIn = nextRandom();
			dhrIn = nextRandom();
			spIn = nextRandom();
			rsId = targetA;
			rtId = targetB;
			runCycle();
			driveIdle();
			rsId = targetA;
			rtId = targetB;
			ruId = regFilePkg::idDhr;
			rvId = regFilePkg::idSp;
			runCycle();
		end
	endtask

	task automatic forwardPriority();
		int i;
		logic [63:0] r;
		regFilePkg::regIdT target;
		for (i = 0; i < 48; i++) begin
			r = nextRandom();
			case (r[2:0])
				3'd0: target = regFilePkg::idImm;	// Constants never forward
				3'd1: target = regFilePkg::idZero;
				3'd2: target = regFilePkg::idSp;
				default: target = {1'b0, r[7:3]};
			endcase
			ex1IdA = r[8] ? target : randomGpr();
			ex1IdB = r[9] ? target : randomGpr();
			ex2IdA = r[10] ? target : randomGpr();
			ex2IdB = r[11] ? target : randomGpr();
			ex3IdA = r[12] ? target : randomGpr();
			ex3IdB = r[13] ? target : randomGpr();
			ex1ValueA = nextRandom();
			ex1ValueB = nextRandom();
			ex2ValueA = nextRandom();
			ex2ValueB = nextRandom();
			ex3ValueA = nextRandom();
			ex3ValueB = nextRandom();
			rsId = target;
			rtId = target;
			ruId = target;
			rvId = r[14] ? target : randomGpr();
			r = nextRandom();
			immA = r[32:0];
			immB = r[63:31];
			runCycle();
		end
	endtask

	task automatic constantSources();
		int i;
		logic [63:0] r;
		for (i = 0; i < 32; i++) begin
			driveIdle();
			r = nextRandom();
			pcValue = r[47:0];
			r = nextRandom();
			immA = r[32:0];
			immB = r[63:31];
			ex1IdA = regFilePkg::idImm;
			ex1ValueA = nextRandom();
			case (i % 4)
				0: begin
					rsId = regFilePkg::idPc;
					rtId = regFilePkg::idPc;
					ruId = regFilePkg::idPc;
					rvId = regFilePkg::idPc;
				end
				1: begin
					rsId = regFilePkg::idImm;
					rtId = regFilePkg::idImm;
					ruId = regFilePkg::idImm;
					rvId = regFilePkg::idImm;
				end
				2: begin
					rvId = {1'b1, r[4:0]};	// Possibly an unused code
				end
				default: begin
					rsId = regFilePkg::idImm;
					rtId = regFilePkg::idPc;
					ruId = regFilePkg::idZero;
					rvId = regFilePkg::idImm;
				end
			endcase
			runCycle();
		end
	endtask

	task automatic specialRegisters();
		int i;
		logic [63:0] r;
		for (i = 0; i < 40; i++) begin
			driveIdle();
			r = nextRandom();
			dlrIn = nextRandom();
			dhrIn = nextRandom();
			spIn = nextRandom();
			ex3IdA = randomDest();
			ex3IdB = r[0] ? ex3IdA : randomDest();
			ex3ValueA = nextRandom();
			ex3ValueB = nextRandom();
			rsId = regFilePkg::idDlr;
			rtId = regFilePkg::idDhr;
			ruId = regFilePkg::idSp;
			rvId = randomDest();
			runCycle();
		end
	endtask

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		driveIdle();
		pcValue = '0;
		immA = '0;
		immB = '0;
		dlrIn = nextRandom();	// Ignored while in reset
		dhrIn = nextRandom();
		spIn = nextRandom();
		dlrModel = '0;
		dhrModel = '0;
		spModel = '0;
		#0.5;
		repeat (5) waitEdge(1'b1);
		#1;
		reset = 1'b0;
		writeAllRegisters();
		randomWrites();
		blockedWrites();
		forwardPriority();
		constantSources();
		specialRegisters();
		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== logic/gprRegFile.sv ====
//////////////////////////////
// Operand register file top level
// Array, special registers and four
// source paths
//////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module gprRegFile #(
	parameter int registerCount = regFilePkg::gprCount
) (
	input logic clock,
	input logic reset,
	input logic hold,
	input logic ex3Flush,
	input regFilePkg::regIdT ex1IdA,
	input regFilePkg::dataT ex1ValueA,
	input regFilePkg::regIdT ex1IdB,
	input regFilePkg::dataT ex1ValueB,
	input regFilePkg::regIdT ex2IdA,
	input regFilePkg::dataT ex2ValueA,
	input regFilePkg::regIdT ex2IdB,
	input regFilePkg::dataT ex2ValueB,
	input regFilePkg::regIdT ex3IdA,
	input regFilePkg::dataT ex3ValueA,
	input regFilePkg::regIdT ex3IdB,
	input regFilePkg::dataT ex3ValueB,
	input regFilePkg::regIdT rsId,
	input regFilePkg::regIdT rtId,
	input regFilePkg::regIdT ruId,
	input regFilePkg::regIdT rvId,
	input regFilePkg::pcT pcValue,
	input regFilePkg::immT immA,
	input regFilePkg::immT immB,
	input regFilePkg::dataT dlrIn,
	input regFilePkg::dataT dhrIn,
	input regFilePkg::dataT spIn,
	output regFilePkg::dataT rsValue,
	output regFilePkg::dataT rtValue,
	output regFilePkg::dataT ruValue,
	output regFilePkg::dataT rvValue,
	output regFilePkg::dataT dlrOut,
	output regFilePkg::dataT dhrOut,
	output regFilePkg::dataT spOut
);

	logic commit;	// EX3 retires this cycle
	regFilePkg::dataT rsGpr, rtGpr, ruGpr, rvGpr;
	regFilePkg::dataT rsBase, rtBase, ruBase, rvBase;
	logic rsConst, rtConst, ruConst, rvConst;

	assign commit = !hold && !ex3Flush;

	gprBankedArray #(.registerCount(registerCount)) gprArray (
		.clock(clock), .reset(reset), .commit(commit),
		.writeIdA(ex3IdA), .writeIdB(ex3IdB),
		.writeValueA(ex3ValueA), .writeValueB(ex3ValueB),
		.readId0(rsId), .readId1(rtId), .readId2(ruId), .readId3(rvId),
		.readValue0(rsGpr), .readValue1(rtGpr),
		.readValue2(ruGpr), .readValue3(rvGpr)
	);

	specialReg #(.regId(regFilePkg::idDlr)) dlrReg (
		.clock(clock), .reset(reset), .commit(commit),
		.writeIdA(ex3IdA), .writeValueA(ex3ValueA),
		.writeIdB(ex3IdB), .writeValueB(ex3ValueB),
		.loadValue(dlrIn), .value(dlrOut)
	);

	specialReg #(.regId(regFilePkg::idDhr)) dhrReg (
		.clock(clock), .reset(reset), .commit(commit),
		.writeIdA(ex3IdA), .writeValueA(ex3ValueA),
		.writeIdB(ex3IdB), .writeValueB(ex3ValueB),
		.loadValue(dhrIn), .value(dhrOut)
	);

	specialReg #(.regId(regFilePkg::idSp)) spReg (
		.clock(clock), .reset(reset), .commit(commit),
		.writeIdA(ex3IdA), .writeValueA(ex3ValueA),
		.writeIdB(ex3IdB), .writeValueB(ex3ValueB),
		.loadValue(spIn), .value(spOut)
	);

	// Lane A sources, only Rs may read the PC
	operandSelect #(.hasPcSource(1'b1)) rsSelect (
		.sourceId(rsId), .gprValue(rsGpr),
		.dlrValue(dlrOut), .dhrValue(dhrOut), .spValue(spOut),
		.pcValue(pcValue), .immValue(immA),
		.value(rsBase), .isConstant(rsConst)
	);

	operandSelect #(.hasPcSource(1'b0)) rtSelect (
		.sourceId(rtId), .gprValue(rtGpr),
		.dlrValue(dlrOut), .dhrValue(dhrOut), .spValue(spOut),
		.pcValue(pcValue), .immValue(immA),
		.value(rtBase), .isConstant(rtConst)
	);

	// Lane B sources
	operandSelect #(.hasPcSource(1'b0)) ruSelect (
		.sourceId(ruId), .gprValue(ruGpr),
		.dlrValue(dlrOut), .dhrValue(dhrOut), .spValue(spOut),
		.pcValue(pcValue), .immValue(immB),
		.value(ruBase), .isConstant(ruConst)
	);

	operandSelect #(.hasPcSource(1'b0)) rvSelect (
		.sourceId(rvId), .gprValue(rvGpr),
		.dlrValue(dlrOut), .dhrValue(dhrOut), .spValue(spOut),
		.pcValue(pcValue), .immValue(immB),
		.value(rvBase), .isConstant(rvConst)
	);

	// Stage pairs connect by name
	forwardNetwork rsForward (
		.sourceId(rsId), .baseValue(rsBase), .isConstant(rsConst),
		.value(rsValue), .*
	);

	forwardNetwork rtForward (
		.sourceId(rtId), .baseValue(rtBase), .isConstant(rtConst),
		.value(rtValue), .*
	);

	forwardNetwork ruForward (
		.sourceId(ruId), .baseValue(ruBase), .isConstant(ruConst),
		.value(ruValue), .*
	);

	forwardNetwork rvForward (
		.sourceId(rvId), .baseValue(rvBase), .isConstant(rvConst),
		.value(rvValue), .*
	);

endmodule

`default_nettype wire

// ==== logic/forwardNetwork.sv ====
//////////////////////////////
// In-flight result forwarding
// for one source port
//////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module forwardNetwork (
	input regFilePkg::regIdT sourceId,
	input regFilePkg::dataT baseValue,
	input logic isConstant,
	input regFilePkg::regIdT ex1IdA,
	input regFilePkg::dataT ex1ValueA,
	input regFilePkg::regIdT ex1IdB,
	input regFilePkg::dataT ex1ValueB,
	input regFilePkg::regIdT ex2IdA,
	input regFilePkg::dataT ex2ValueA,
	input regFilePkg::regIdT ex2IdB,
	input regFilePkg::dataT ex2ValueB,
	input regFilePkg::regIdT ex3IdA,
	input regFilePkg::dataT ex3ValueA,
	input regFilePkg::regIdT ex3IdB,
	input regFilePkg::dataT ex3ValueB,
	output regFilePkg::dataT value
);

	// Youngest stage first, lane A ahead of lane B
	always_comb begin
		value = baseValue;
		if (!isConstant) begin
			if (sourceId == ex1IdA) begin
				value = ex1ValueA;
			end else if (sourceId == ex1IdB) begin
				value = ex1ValueB;
			end else if (sourceId == ex2IdA) begin
				value = ex2ValueA;
			end else if (sourceId == ex2IdB) begin
				value = ex2ValueB;
			end else if (sourceId == ex3IdA) begin
				value = ex3ValueA;	// Not yet in the array
			end else if (sourceId == ex3IdB) begin
				value = ex3ValueB;
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/operandSelect.sv ====
//////////////////////////////
// Source ID decode to register
// value or constant operand
//////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module operandSelect #(
	parameter bit hasPcSource = 1'b0
) (
	input regFilePkg::regIdT sourceId,
	input regFilePkg::dataT gprValue,
	input regFilePkg::dataT dlrValue,
	input regFilePkg::dataT dhrValue,
	input regFilePkg::dataT spValue,
	input regFilePkg::pcT pcValue,
	input regFilePkg::immT immValue,
	output regFilePkg::dataT value,
	output logic isConstant
);

	localparam int topBit = regFilePkg::regIdWidth - 1;
	localparam int pcPad = regFilePkg::dataWidth - regFilePkg::pcWidth;
	localparam int immPad = regFilePkg::dataWidth - regFilePkg::immWidth;

	regFilePkg::dataT pcOperand;
	regFilePkg::dataT immOperand;

	// PC with the low bit cleared
	assign pcOperand = {{pcPad{1'b0}}, pcValue[regFilePkg::pcWidth-1:1], 1'b0};
	assign immOperand = {{immPad{immValue[regFilePkg::immWidth-1]}}, immValue};

	always_comb begin
		value = '0;
		isConstant = 1'b0;
		if (!sourceId[topBit]) begin
			value = gprValue;
		end else begin
			case (sourceId)
				regFilePkg::idDlr: value = dlrValue;
				regFilePkg::idDhr: value = dhrValue;
				regFilePkg::idSp: value = spValue;
				regFilePkg::idPc: begin
					if (hasPcSource) begin
						value = pcOperand;
					end
				end
				regFilePkg::idImm: begin
					value = immOperand;
					isConstant = 1'b1;
				end
				regFilePkg::idZero: isConstant = 1'b1;
				default: value = '0;	// Unused IDs read as zero
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== logic/specialReg.sv ====
//////////////////////////////
// One special register, written
// by either lane or loaded
//////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module specialReg #(
	parameter regFilePkg::regIdT regId = regFilePkg::idDlr
) (
	input logic clock,
	input logic reset,
	input logic commit,
	input regFilePkg::regIdT writeIdA,
	input regFilePkg::dataT writeValueA,
	input regFilePkg::regIdT writeIdB,
	input regFilePkg::dataT writeValueB,
	input regFilePkg::dataT loadValue,
	output regFilePkg::dataT value
);

	always_ff @(posedge clock) begin
		if (reset) begin
			value <= '0;
		end else if (commit) begin
			if (writeIdB == regId) begin
				value <= writeValueB;	// Lane B has priority
			end else if (writeIdA == regId) begin
				value <= writeValueA;
			end else begin
				value <= loadValue;	// Follow the outside copy
			end
		end
	end

endmodule

`default_nettype wire

// ==== logic/gprBankedArray.sv ====
//////////////////////////////
// Two-bank general register array
// with per-register bank bits
//////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module gprBankedArray #(
	parameter int registerCount = regFilePkg::gprCount
) (
	input logic clock,
	input logic reset,
	input logic commit,
	input regFilePkg::regIdT writeIdA,
	input regFilePkg::regIdT writeIdB,
	input regFilePkg::dataT writeValueA,
	input regFilePkg::dataT writeValueB,
	input regFilePkg::regIdT readId0,
	input regFilePkg::regIdT readId1,
	input regFilePkg::regIdT readId2,
	input regFilePkg::regIdT readId3,
	output regFilePkg::dataT readValue0,
	output regFilePkg::dataT readValue1,
	output regFilePkg::dataT readValue2,
	output regFilePkg::dataT readValue3
);

	localparam int indexWidth = $clog2(registerCount);
	localparam int topBit = regFilePkg::regIdWidth - 1;

	regFilePkg::dataT bankA [registerCount];	// Lane A results
	regFilePkg::dataT bankB [registerCount];	// Lane B results
	logic [registerCount-1:0] bankSel;	// Set means bank B is newest

	logic writeEnA;
	logic writeEnB;

	// Only general register IDs land in the array
	assign writeEnA = commit && !writeIdA[topBit];
	assign writeEnB = commit && !writeIdB[topBit];

	always_ff @(posedge clock) begin
		if (reset) begin
			bankSel <= '0;
		end else begin
			if (writeEnA) begin
				bankSel[writeIdA[indexWidth-1:0]] <= 1'b0;
			end
			// Same register on both lanes leaves bank B selected
			if (writeEnB) begin
				bankSel[writeIdB[indexWidth-1:0]] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (writeEnA) begin
			bankA[writeIdA[indexWidth-1:0]] <= writeValueA;
		end
		if (writeEnB) begin
			bankB[writeIdB[indexWidth-1:0]] <= writeValueB;
		end
	end

	// Four combinational read ports
	assign readValue0 = bankSel[readId0[indexWidth-1:0]] ?
		bankB[readId0[indexWidth-1:0]] : bankA[readId0[indexWidth-1:0]];
	assign readValue1 = bankSel[readId1[indexWidth-1:0]] ?
		bankB[readId1[indexWidth-1:0]] : bankA[readId1[indexWidth-1:0]];
	assign readValue2 = bankSel[readId2[indexWidth-1:0]] ?
		bankB[readId2[indexWidth-1:0]] : bankA[readId2[indexWidth-1:0]];
	assign readValue3 = bankSel[readId3[indexWidth-1:0]] ?
		bankB[readId3[indexWidth-1:0]] : bankA[readId3[indexWidth-1:0]];

endmodule

`default_nettype wire

// ==== logic/regFilePkg.sv ====
//////////////////////////////
// Register file widths, operand types
// and source register-ID codes
//////////////////////////////

`default_nettype none

package regFilePkg;

	localparam int dataWidth = 64;
	localparam int pcWidth = 48;
	localparam int immWidth = 33;	// Bit 32 carries the sign
	localparam int regIdWidth = 6;
	localparam int gprCount = 32;

	typedef logic [dataWidth-1:0] dataT;
	typedef logic [regIdWidth-1:0] regIdT;
	typedef logic [immWidth-1:0] immT;
	typedef logic [pcWidth-1:0] pcT;

	// IDs 0 to 31 name the general registers
	// With the top bit set an ID names some other source
	localparam regIdT idDlr = 6'd32;
	localparam regIdT idDhr = 6'd33;
	localparam regIdT idSp = 6'd34;
	localparam regIdT idPc = 6'd35;	// Rs port only
	localparam regIdT idImm = 6'd36;	// Lane immediate
	localparam regIdT idZero = 6'd37;	// Also "no destination"

endpackage

`default_nettype wire
